/* source/lsu_pkg.sv */
package lsu_pkg;

  localparam int CPU_WIDTH = 32;

  typedef logic [CPU_WIDTH-1:0]   cpu_word_t;
  typedef logic [CPU_WIDTH/8-1:0] strb_t;
  typedef logic [3:0]             axi_id_t;
  typedef logic [7:0]             axi_len_t;
  typedef logic [2:0]             axi_size_t;
  typedef logic [1:0]             axi_burst_t;
  typedef logic [1:0]             axi_resp_t;

  localparam axi_burst_t AXI_BURST_INCR = 2'b01;
  localparam axi_resp_t  AXI_RESP_OKAY  = 2'b00;

  // Odd encodings are stores
  typedef enum logic [3:0] {
    LSU_NOP = 4'b0000,
    LSU_LB  = 4'b0010,
    LSU_LH  = 4'b0100,
    LSU_LW  = 4'b0110,
    LSU_LBU = 4'b1000,
    LSU_LHU = 4'b1010,
    LSU_SB  = 4'b0001,
    LSU_SH  = 4'b0011,
    LSU_SW  = 4'b0101
  } lsu_op_t;

  typedef struct packed {
    lsu_op_t   op;
    cpu_word_t addr;
    cpu_word_t regst;
  } lsu_req_t;

  typedef struct packed {
    cpu_word_t  addr;
    axi_id_t    id;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_aw_t;

  typedef struct packed {
    cpu_word_t  addr;
    axi_id_t    id;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_ar_t;

  typedef struct packed {
    cpu_word_t data;
    strb_t     strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_resp_t resp;
    axi_id_t   id;
  } axi_b_t;

  typedef struct packed {
    cpu_word_t data;
    axi_resp_t resp;
    logic      last;
    axi_id_t   id;
  } axi_r_t;

endpackage

/* source/lsu_store_path.sv */
module lsu_store_path (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_start,
  input  lsu_pkg::lsu_op_t   i_op,
  input  lsu_pkg::cpu_word_t i_addr,
  input  lsu_pkg::cpu_word_t i_regst,
  // AW
  output logic               o_awvalid,
  input  logic               i_awready,
  output lsu_pkg::axi_aw_t   o_aw,
  // W
  output logic               o_wvalid,
  input  logic               i_wready,
  output lsu_pkg::axi_w_t    o_w,
  // B
  input  logic               i_bvalid,
  input  lsu_pkg::axi_b_t    i_b,
  output logic               o_bready,
  output logic               o_done
);

  import lsu_pkg::*;

  axi_size_t size_c;
  strb_t     mask_c;
  axi_aw_t   aw_q;
  axi_w_t    w_q;
  logic      awvalid_q;
  logic      wvalid_q;
  logic      bready_q;
  logic      done_q;
  logic      b_hs;

  // Transfer size and unshifted byte mask per store width
  always_comb begin
    case (i_op)
      LSU_SB: begin
        size_c = 3'd0;
        mask_c = 4'b0001;
      end
      LSU_SH: begin
        size_c = 3'd1;
        mask_c = 4'b0011;
      end
      LSU_SW: begin
        size_c = 3'd2;
        mask_c = 4'b1111;
      end
      default: begin
        size_c = 3'd0;
        mask_c = 4'b0000;
      end
    endcase
  end

  // Address and data held until the handshakes
  always_ff @(posedge i_clk) begin
    if (i_start) begin
      aw_q.addr  <= i_addr;
      aw_q.id    <= '0;
      aw_q.len   <= '0;
      aw_q.size  <= size_c;
      aw_q.burst <= AXI_BURST_INCR;
      w_q.data   <= i_regst << {i_addr[1:0], 3'b000};
      w_q.strb   <= mask_c << i_addr[1:0];
      w_q.last   <= 1'b1;
    end
  end

  // Only the response to our own write counts
  assign b_hs = i_bvalid && bready_q && (i_b.id == aw_q.id);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      bready_q  <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      if (i_start) begin
        awvalid_q <= 1'b1;
      end else if (awvalid_q && i_awready) begin
        awvalid_q <= 1'b0;
      end
      if (i_start) begin
        wvalid_q <= 1'b1;
      end else if (wvalid_q && i_wready) begin
        wvalid_q <= 1'b0;
      end
      // Ready follows valid by one cycle
      bready_q <= i_bvalid && !bready_q;
      done_q   <= b_hs;
    end
  end

  assign o_awvalid = awvalid_q;
  assign o_aw      = aw_q;
  assign o_wvalid  = wvalid_q;
  assign o_w       = w_q;
  assign o_bready  = bready_q;
  assign o_done    = done_q;

endmodule

/* source/lsu_load_path.sv */
module lsu_load_path (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_start,
  input  lsu_pkg::lsu_op_t   i_op,
  input  lsu_pkg::cpu_word_t i_addr,
  // AR
  output logic               o_arvalid,
  input  logic               i_arready,
  output lsu_pkg::axi_ar_t   o_ar,
  // R
  input  logic               i_rvalid,
  input  lsu_pkg::axi_r_t    i_r,
  output logic               o_rready,
  output logic               o_done,
  output lsu_pkg::cpu_word_t o_data
);

  import lsu_pkg::*;

  axi_size_t size_c;
  axi_ar_t   ar_q;
  lsu_op_t   op_q;
  logic      arvalid_q;
  logic      rready_q;
  logic      done_q;
  cpu_word_t data_q;
  cpu_word_t shifted;
  cpu_word_t load_c;
  logic      r_hs;

  always_comb begin
    case (i_op)
      LSU_LB, LSU_LBU: size_c = 3'd0;
      LSU_LH, LSU_LHU: size_c = 3'd1;
      LSU_LW:          size_c = 3'd2;
      default:         size_c = 3'd0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      ar_q.addr  <= i_addr;
      ar_q.id    <= '0;
      ar_q.len   <= '0;
      ar_q.size  <= size_c;
      ar_q.burst <= AXI_BURST_INCR;
      op_q       <= i_op;
    end
  end

  // Bring the addressed byte down to bit 0
  assign shifted = i_r.data >> {ar_q.addr[1:0], 3'b000};

  always_comb begin
    case (op_q)
      LSU_LB:  load_c = {{(CPU_WIDTH-8){shifted[7]}}, shifted[7:0]};
      LSU_LH:  load_c = {{(CPU_WIDTH-16){shifted[15]}}, shifted[15:0]};
      LSU_LBU: load_c = {{(CPU_WIDTH-8){1'b0}}, shifted[7:0]};
      LSU_LHU: load_c = {{(CPU_WIDTH-16){1'b0}}, shifted[15:0]};
      LSU_LW:  load_c = shifted;
      default: load_c = '0;
    endcase
  end

  assign r_hs = i_rvalid && rready_q && i_r.last && (i_r.id == ar_q.id);

  always_ff @(posedge i_clk) begin
    if (r_hs) begin
      data_q <= load_c;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      arvalid_q <= 1'b0;
      rready_q  <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      if (i_start) begin
        arvalid_q <= 1'b1;
      end else if (arvalid_q && i_arready) begin
        arvalid_q <= 1'b0;
      end
      rready_q <= i_rvalid && !rready_q;
      // Pulses together with the new data_q
      done_q   <= r_hs;
    end
  end

  assign o_arvalid = arvalid_q;
  assign o_ar      = ar_q;
  assign o_rready  = rready_q;
  assign o_done    = done_q;
  assign o_data    = data_q;

endmodule

/* source/lsu_complete.sv */
module lsu_complete (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_nop_done,
  input  logic               i_store_done,
  input  logic               i_load_done,
  input  lsu_pkg::cpu_word_t i_load_data,
  input  logic               i_post_ready,
  output logic               o_post_valid,
  output lsu_pkg::cpu_word_t o_regld,
  output logic               o_idle
);

  import lsu_pkg::*;

  logic      valid_q;
  cpu_word_t regld_q;
  logic      any_done;
  logic      post_hs;

  // At most one source fires per operation
  assign any_done = i_nop_done || i_store_done || i_load_done;
  assign post_hs  = valid_q && i_post_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else begin
      if (any_done) begin
        valid_q <= 1'b1;
      end else if (post_hs) begin
        valid_q <= 1'b0;
      end
    end
  end

  // Stores and NOPs write nothing back
  always_ff @(posedge i_clk) begin
    if (any_done) begin
      if (i_load_done) begin
        regld_q <= i_load_data;
      end else begin
        regld_q <= '0;
      end
    end
  end

  assign o_post_valid = valid_q;
  assign o_regld      = regld_q;
  // Result taken, unit may accept again
  assign o_idle       = post_hs;

endmodule

/* source/axi_sram.sv */
module axi_sram #(
  parameter int MEM_WORDS  = 256,
  parameter int RESP_DELAY = 2
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_awvalid,
  output logic              o_awready,
  input  lsu_pkg::axi_aw_t  i_aw,
  input  logic              i_wvalid,
  output logic              o_wready,
  input  lsu_pkg::axi_w_t   i_w,
  output logic              o_bvalid,
  input  logic              i_bready,
  output lsu_pkg::axi_b_t   o_b,
  input  logic              i_arvalid,
  output logic              o_arready,
  input  lsu_pkg::axi_ar_t  i_ar,
  output logic              o_rvalid,
  input  logic              i_rready,
  output lsu_pkg::axi_r_t   o_r
);

  import lsu_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int CNT_W = $clog2(RESP_DELAY + 2);

  typedef enum logic [1:0] {
    IDLE,
    WRITE_WAIT,
    READ_WAIT,
    RESP
  } state_t;

  state_t           state_q;
  cpu_word_t        mem [MEM_WORDS];
  logic             wr_rdy_q;
  logic             ar_rdy_q;
  logic             bvalid_q;
  logic             rvalid_q;
  logic [CNT_W-1:0] cnt_q;
  axi_id_t          id_q;
  cpu_word_t        rdata_q;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic             wr_hs;
  logic             rd_hs;

  assign wr_idx = i_aw.addr[IDX_W+1:2];
  assign rd_idx = i_ar.addr[IDX_W+1:2];
  assign wr_hs  = wr_rdy_q && i_awvalid && i_wvalid;
  assign rd_hs  = ar_rdy_q && i_arvalid;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_hs) begin
      for (int b = 0; b < CPU_WIDTH / 8; b++) begin
        if (i_w.strb[b]) begin
          mem[wr_idx][8*b +: 8] <= i_w.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (rd_hs) begin
      rdata_q <= mem[rd_idx];
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q  <= IDLE;
      wr_rdy_q <= 1'b0;
      ar_rdy_q <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      cnt_q    <= '0;
      id_q     <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (wr_hs) begin
            wr_rdy_q <= 1'b0;
            id_q     <= i_aw.id;
            cnt_q    <= CNT_W'(1);
            state_q  <= WRITE_WAIT;
          end else if (rd_hs) begin
            ar_rdy_q <= 1'b0;
            id_q     <= i_ar.id;
            cnt_q    <= CNT_W'(1);
            state_q  <= READ_WAIT;
          end else if (!wr_rdy_q && !ar_rdy_q) begin
            // Writes win when both sides are waiting
            if (i_awvalid && i_wvalid) begin
              wr_rdy_q <= 1'b1;
            end else if (i_arvalid) begin
              ar_rdy_q <= 1'b1;
            end
          end
        end
        WRITE_WAIT: begin
          if (cnt_q >= CNT_W'(RESP_DELAY)) begin
            bvalid_q <= 1'b1;
            state_q  <= RESP;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        READ_WAIT: begin
          if (cnt_q >= CNT_W'(RESP_DELAY)) begin
            rvalid_q <= 1'b1;
            state_q  <= RESP;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RESP: begin
          // Hold the response until the master takes it
          if ((bvalid_q && i_bready) || (rvalid_q && i_rready)) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            state_q  <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign o_awready = wr_rdy_q;
  assign o_wready  = wr_rdy_q;
  assign o_arready = ar_rdy_q;
  assign o_bvalid  = bvalid_q;
  assign o_b.resp  = AXI_RESP_OKAY;
  assign o_b.id    = id_q;
  assign o_rvalid  = rvalid_q;
  assign o_r.data  = rdata_q;
  assign o_r.resp  = AXI_RESP_OKAY;
  assign o_r.last  = 1'b1;
  assign o_r.id    = id_q;

endmodule

/* source/lsu_top.sv */
module lsu_top #(
  parameter int MEM_WORDS  = 256,
  parameter int RESP_DELAY = 2
) (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_pre_valid,
  output logic               o_pre_ready,
  input  lsu_pkg::lsu_req_t  i_req,
  output logic               o_post_valid,
  input  logic               i_post_ready,
  output lsu_pkg::cpu_word_t o_regld
);

  import lsu_pkg::*;

  logic      busy_q;
  lsu_op_t   op_q;
  logic      accept;
  logic      store_start;
  logic      load_start;
  logic      nop_start;
  logic      store_done;
  logic      load_done;
  cpu_word_t load_data;
  logic      idle;

  logic      awvalid;
  logic      awready;
  axi_aw_t   aw;
  logic      wvalid;
  logic      wready;
  axi_w_t    w;
  logic      bvalid;
  logic      bready;
  axi_b_t    b;
  logic      arvalid;
  logic      arready;
  axi_ar_t   ar;
  logic      rvalid;
  logic      rready;
  axi_r_t    r;

  // One operation in flight at a time
  assign o_pre_ready = !busy_q && i_post_ready;
  assign accept      = i_pre_valid && o_pre_ready;
  assign store_start = accept && i_req.op[0];
  assign load_start  = accept && !i_req.op[0] && (i_req.op != LSU_NOP);
  assign nop_start   = accept && (i_req.op == LSU_NOP);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy_q <= 1'b0;
      op_q   <= LSU_NOP;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
        op_q   <= i_req.op;
      end else if (idle) begin
        busy_q <= 1'b0;
      end
    end
  end

  lsu_store_path u_store_path (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_start   (store_start),
    .i_op      (i_req.op),
    .i_addr    (i_req.addr),
    .i_regst   (i_req.regst),
    .o_awvalid (awvalid),
    .i_awready (awready),
    .o_aw      (aw),
    .o_wvalid  (wvalid),
    .i_wready  (wready),
    .o_w       (w),
    .i_bvalid  (bvalid),
    .i_b       (b),
    .o_bready  (bready),
    .o_done    (store_done)
  );

  lsu_load_path u_load_path (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_start   (load_start),
    .i_op      (i_req.op),
    .i_addr    (i_req.addr),
    .o_arvalid (arvalid),
    .i_arready (arready),
    .o_ar      (ar),
    .i_rvalid  (rvalid),
    .i_r       (r),
    .o_rready  (rready),
    .o_done    (load_done),
    .o_data    (load_data)
  );

  // Completions only count for the kind of operation in flight
  lsu_complete u_complete (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_nop_done   (nop_start),
    .i_store_done (store_done && op_q[0]),
    .i_load_done  (load_done && !op_q[0]),
    .i_load_data  (load_data),
    .i_post_ready (i_post_ready),
    .o_post_valid (o_post_valid),
    .o_regld      (o_regld),
    .o_idle       (idle)
  );

  axi_sram #(
    .MEM_WORDS  (MEM_WORDS),
    .RESP_DELAY (RESP_DELAY)
  ) u_sram (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_aw      (aw),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .i_w       (w),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .o_b       (b),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .i_ar      (ar),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_r       (r)
  );

endmodule

/* verification/lsu_tb.sv */
module lsu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int SEED           = 16480;

  logic      i_clk;
  logic      i_rst_n;
  logic      i_pre_valid;
  logic      o_pre_ready;
  lsu_req_t  i_req;
  logic      o_post_valid;
  logic      i_post_ready;
  cpu_word_t o_regld;

  int error_count;
  int test_count;
  int fail_count;
  bit broken;

  lsu_top #(
    .MEM_WORDS  (256),
    .RESP_DELAY (2)
  ) DUT (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_pre_valid  (i_pre_valid),
    .o_pre_ready  (o_pre_ready),
    .i_req        (i_req),
    .o_post_valid (o_post_valid),
    .i_post_ready (i_post_ready),
    .o_regld      (o_regld)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  task automatic check_word(input string name, input cpu_word_t expected,
                            input cpu_word_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input bit passed);
    test_count++;
    if (passed) begin
      $display("%-14s ok", name);
    end else begin
      fail_count++;
      $display("%-14s failed", name);
    end
  endtask

  task automatic wait_pre_ready(input string name, output bit ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < TIMEOUT_CYCLES) begin
      @(negedge i_clk);
      ok = o_pre_ready;
      cycles++;
    end
    if (!ok) begin
      $display("Timeout in %s: the unit never became ready for a request", name);
    end
  endtask

  task automatic wait_post_valid(input string name, output bit ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < TIMEOUT_CYCLES) begin
      @(negedge i_clk);
      ok = o_post_valid;
      cycles++;
    end
    if (!ok) begin
      $display("Timeout in %s: the operation never completed", name);
    end
  endtask

  function automatic bit parse_op(input string s, output lsu_op_t op);
    parse_op = 1'b1;
    case (s)
      "NOP":   op = LSU_NOP;
      "LB":    op = LSU_LB;
      "LH":    op = LSU_LH;
      "LW":    op = LSU_LW;
      "LBU":   op = LSU_LBU;
      "LHU":   op = LSU_LHU;
      "SB":    op = LSU_SB;
      "SH":    op = LSU_SH;
      "SW":    op = LSU_SW;
      default: begin
        op = LSU_NOP;
        parse_op = 1'b0;
      end
    endcase
  endfunction

  // One request through acceptance, optional stall and the post-stage transfer
  task automatic run_test(input string name, input lsu_op_t op, input cpu_word_t addr,
                          input cpu_word_t wdata, input cpu_word_t expected,
                          input int stall, output bit ok);
    int errors_before;
    errors_before = error_count;
    wait_pre_ready(name, ok);
    if (ok) begin
      @(posedge i_clk);
      #1;
      i_pre_valid = 1'b1;
      i_req.op    = op;
      i_req.addr  = addr;
      i_req.regst = wdata;
      @(posedge i_clk);
      #1;
      i_pre_valid  = 1'b0;
      i_post_ready = (stall == 0);
      wait_post_valid(name, ok);
    end
    if (ok && stall > 0) begin
      for (int k = 0; k < stall; k++) begin
        check_flag({name, " stalled o_post_valid"}, 1'b1, o_post_valid);
        check_word({name, " stalled o_regld"}, expected, o_regld);
        check_flag({name, " stalled o_pre_ready"}, 1'b0, o_pre_ready);
        @(negedge i_clk);
      end
      @(posedge i_clk);
      #1;
      i_post_ready = 1'b1;
      @(negedge i_clk);
    end
    if (ok) begin
      check_flag({name, " o_post_valid"}, 1'b1, o_post_valid);
      check_word(name, expected, o_regld);
      // Still busy until the result is taken
      check_flag({name, " o_pre_ready while busy"}, 1'b0, o_pre_ready);
      // Result transfers on the next edge
      @(negedge i_clk);
      check_flag({name, " o_post_valid after transfer"}, 1'b0, o_post_valid);
      check_flag({name, " o_pre_ready after transfer"}, 1'b1, o_pre_ready);
    end
    report_test(name, ok && error_count == errors_before);
  endtask

  initial begin
    int        fd;
    int        fields;
    int        stall;
    int        base_errors;
    string     line;
    string     name;
    string     op_name;
    string     stall_name;
    cpu_word_t addr;
    cpu_word_t wdata;
    cpu_word_t expected;
    lsu_op_t   op;
    bit        ok;

    i_rst_n      = 1'b0;
    i_pre_valid  = 1'b0;
    i_req        = '0;
    i_post_ready = 1'b0;
    error_count  = 0;
    test_count   = 0;
    fail_count   = 0;
    broken       = 1'b0;
    void'($urandom(SEED));

    repeat (5) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;

    // Idle after reset, ready tracks i_post_ready
    base_errors = error_count;
    @(negedge i_clk);
    check_flag("reset o_post_valid", 1'b0, o_post_valid);
    check_flag("reset o_pre_ready low", 1'b0, o_pre_ready);
    @(posedge i_clk);
    #1;
    i_post_ready = 1'b1;
    @(negedge i_clk);
    check_flag("reset o_pre_ready high", 1'b1, o_pre_ready);
    check_flag("reset o_post_valid idle", 1'b0, o_post_valid);
    report_test("reset_state", error_count == base_errors);

    fd = $fopen("verification/lsu_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file verification/lsu_input.txt");
      broken = 1'b1;
    end
    while (!broken && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%s %s %h %h %h %s", name, op_name, addr, wdata,
                         expected, stall_name);
        if (fields == 6 && parse_op(op_name, op)) begin
          if (stall_name == "r") begin
            stall = int'($urandom % 6) + 1;
          end else begin
            stall = stall_name.atoi();
          end
          run_test(name, op, addr, wdata, expected, stall, ok);
          broken = !ok;
        end else if (fields > 0) begin
          $display("A line of the vector file could not be read: %s", line);
          broken = 1'b1;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("Summary: %0d tests, %0d failed, %0d check errors", test_count, fail_count,
             error_count);
    if (error_count == 0 && fail_count == 0 && !broken) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* sim.f */
source/lsu_pkg.sv
source/lsu_store_path.sv
source/lsu_load_path.sv
source/lsu_complete.sv
source/axi_sram.sv
source/lsu_top.sv
verification/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the LSU testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module lsu_tb -o lsu_sim || exit 1
out=$(./obj_dir/lsu_sim)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}

/* verification/lsu_input.txt */
# name op addr store_data expected_regld stall
# hex values; stall is cycles with i_post_ready low, r picks a random count
sw_a         SW  00000010 deadbeef 00000000 0
lw_a         LW  00000010 00000000 deadbeef 0
sw_b         SW  00000020 12345678 00000000 0
sb_0         SB  00000020 000000aa 00000000 0
sb_3         SB  00000023 000000bb 00000000 1
sh_2         SH  00000022 0000cafe 00000000 0
lw_merge     LW  00000020 00000000 cafe56aa 3
sb_1         SB  00000021 11111177 00000000 0
sb_2         SB  00000022 00000099 00000000 0
sh_0         SH  00000024 ffff8001 00000000 0
lw_merge2    LW  00000020 00000000 ca9977aa r
lw_half      LW  00000024 00000000 00008001 0
lb_0         LB  00000020 00000000 ffffffaa 0
lb_1         LB  00000021 00000000 00000077 0
lb_2         LB  00000022 00000000 ffffff99 2
lbu_3        LBU 00000023 00000000 000000ca 0
lh_0         LH  00000020 00000000 000077aa 0
lh_2         LH  00000022 00000000 ffffca99 0
lhu_2        LHU 00000022 00000000 0000ca99 0
lh_neg       LH  00000024 00000000 ffff8001 0
lhu_neg      LHU 00000024 00000000 00008001 r
nop_a        NOP 00000010 55555555 00000000 2
lw_after_nop LW  00000010 00000000 deadbeef 0
sw_stall     SW  00000030 a5a5a5a5 00000000 r
lw_stall     LW  00000030 00000000 a5a5a5a5 4
sh_1         SH  00000031 00001234 00000000 0
lh_1         LH  00000031 00000000 00001234 0
lw_end       LW  00000030 00000000 a51234a5 0
